//--- rtl/xlat_pkg.sv
`default_nettype none

package xlat_pkg;

   // ----------------------------------------------------------
   // master side widths (word units)
   // ----------------------------------------------------------
   localparam int AV_ADDRESS_W    = 32;
   localparam int AV_DATA_W       = 32;
   localparam int AV_BURSTCOUNT_W = 4;

   // bytes per word and the matching shift
   localparam int SYMBOLS_PER_WORD = 4;
   localparam int WORD_SHIFT       = 2;
   localparam int BYTEENABLE_W     = 4;

   // ----------------------------------------------------------
   // downstream widths (byte units)
   // ----------------------------------------------------------
   localparam int UAV_ADDRESS_W    = 34;
   localparam int UAV_BURSTCOUNT_W = 6;

   typedef logic [AV_ADDRESS_W-1:0]     av_addr_t;
   typedef logic [UAV_ADDRESS_W-1:0]    uav_addr_t;
   typedef logic [AV_BURSTCOUNT_W-1:0]  burstlen_t;
   typedef logic [UAV_BURSTCOUNT_W-1:0] uav_burst_t;
   typedef logic [AV_DATA_W-1:0]        data_t;
   typedef logic [BYTEENABLE_W-1:0]     byteen_t;

   // beat phase: fresh means the next valid command starts a transfer
   typedef enum logic {
      BEAT_FRESH,
      BEAT_HELD
   } beat_state_t;

   // burst phase: idle means the next write beat opens a burst
   typedef enum logic {
      BURST_IDLE,
      BURST_ACTIVE
   } burst_state_t;

endpackage

`default_nettype wire

//--- rtl/transfer_framer.sv
`default_nettype none

// marks the first cycle of each transfer and of each write burst
module transfer_framer (
   input  logic clk,
   input  logic reset,
   input  logic write,
   input  logic read,
   input  logic uav_waitrequest,
   input  logic last_beat,
   output logic begin_beat,
   output logic begin_burst
);
   import xlat_pkg::*;

   beat_state_t  beat_state;
   beat_state_t  beat_next;
   burst_state_t burst_state;
   burst_state_t burst_next;
   logic         cmd_valid;

   assign cmd_valid = write | read;

   // ----------------------------------------------------------
   // transfer and burst markers
   // ----------------------------------------------------------

   // only the first cycle of a stalled beat counts as its start
   assign begin_beat = cmd_valid && (beat_state != BEAT_HELD);

   // every read is a burst of its own; writes open a burst only when idle
   assign begin_burst = read ? begin_beat
                             : (begin_beat && (burst_state == BURST_IDLE));

   // ----------------------------------------------------------
   // beat phase
   // ----------------------------------------------------------
   always_comb begin
      beat_next = beat_state;
      case (beat_state)
         BEAT_FRESH: begin
            // a beat that starts under wait request stays held
            if (cmd_valid && uav_waitrequest) begin
               beat_next = BEAT_HELD;
            end
         end
         BEAT_HELD: begin
            if (!uav_waitrequest) begin
               beat_next = BEAT_FRESH;
            end
         end
         default: begin
            beat_next = BEAT_FRESH;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beat_state <= BEAT_FRESH;
      end else begin
         beat_state <= beat_next;
      end
   end

   // ----------------------------------------------------------
   // burst phase
   // ----------------------------------------------------------
   always_comb begin
      burst_next = burst_state;
      case (burst_state)
         BURST_IDLE: begin
            // a single-word write opens and closes in the same beat
            if (!read && write && begin_beat && !last_beat) begin
               burst_next = BURST_ACTIVE;
            end
         end
         BURST_ACTIVE: begin
            // a read also ends any pending write burst
            if (read || (begin_beat && last_beat)) begin
               burst_next = BURST_IDLE;
            end
         end
         default: begin
            burst_next = BURST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burst_state <= BURST_IDLE;
      end else begin
         burst_state <= burst_next;
      end
   end

endmodule

`default_nettype wire

//--- rtl/burst_tracker.sv
`default_nettype none

// converts word address and word count to byte units, and steps the
// byte address and remaining length through a write burst
module burst_tracker (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 write,
   input  xlat_pkg::av_addr_t   address,
   input  xlat_pkg::burstlen_t  burstcount,
   input  logic                 begin_beat,
   input  logic                 begin_burst,
   input  logic                 uav_waitrequest,
   output xlat_pkg::uav_addr_t  uav_address,
   output xlat_pkg::uav_burst_t uav_burstcount,
   output logic                 last_beat
);
   import xlat_pkg::*;

   // converted master command
   uav_addr_t  address_pre;
   uav_burst_t burstcount_pre;

   // per-beat state
   uav_addr_t  address_reg;
   uav_addr_t  address_cur;
   burstlen_t  burstlen_reg;
   uav_burst_t burstcount_reg;

   // stall tracking
   logic       first_burst_stalled;
   logic       burst_stalled;

   // final-word detection
   logic       last_pre;
   logic       last_reg;

   // ----------------------------------------------------------
   // word to byte conversion
   // ----------------------------------------------------------
   assign address_pre    = uav_addr_t'(address) << WORD_SHIFT;
   assign burstcount_pre = uav_burst_t'(burstcount) << WORD_SHIFT;

   // remaining length scaled back to bytes
   assign burstcount_reg = uav_burst_t'(burstlen_reg) << WORD_SHIFT;

   // ----------------------------------------------------------
   // output selection
   // ----------------------------------------------------------

   // first beat shows the master's own values, later beats the registers
   always_comb begin
      if (begin_burst) begin
         uav_address    = address_pre;
         uav_burstcount = burstcount_pre;
      end else begin
         uav_address    = address_reg;
         uav_burstcount = burstcount_reg;
      end
   end

   // address of the beat on the bus this cycle
   assign address_cur = begin_burst ? address_pre : address_reg;

   // ----------------------------------------------------------
   // last beat
   // ----------------------------------------------------------

   // both compares sit ahead of the select to keep the path short
   assign last_pre  = (burstcount == burstlen_t'(1));
   assign last_reg  = (burstlen_reg == burstlen_t'(1));
   assign last_beat = write && (begin_burst ? last_pre : last_reg);

   // ----------------------------------------------------------
   // address register
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address_reg <= '0;
      end else if (uav_waitrequest) begin
         // stalled, keep the address of the waiting beat
         address_reg <= address_cur;
      end else if (write) begin
         // accepted write beat, step one word
         address_reg <= address_cur + uav_addr_t'(SYMBOLS_PER_WORD);
      end
   end

   // ----------------------------------------------------------
   // remaining length and stall flags
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burstlen_reg        <= '0;
         first_burst_stalled <= 1'b0;
         burst_stalled       <= 1'b0;
      end else if (begin_burst || first_burst_stalled) begin
         // first beat: load the full count, count it once accepted
         first_burst_stalled <= uav_waitrequest;
         if (uav_waitrequest) begin
            burstlen_reg <= burstcount;
         end else begin
            burstlen_reg <= burstcount - burstlen_t'(1);
         end
      end else if (begin_beat || burst_stalled) begin
         // mid-burst beat: count down only on acceptance
         burst_stalled <= uav_waitrequest;
         if (!uav_waitrequest) begin
            burstlen_reg <= burstlen_reg - burstlen_t'(1);
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/master_translator.sv
`default_nettype none

// word-addressed fixed-burst master to byte-addressed per-beat downstream bus
module master_translator (
   input  logic                 clk,
   input  logic                 reset,

   // ----------------------------------------------------------
   // master side
   // ----------------------------------------------------------
   input  logic                 write,
   input  logic                 read,
   input  xlat_pkg::av_addr_t   address,
   input  xlat_pkg::burstlen_t  burstcount,
   input  xlat_pkg::data_t      writedata,
   input  xlat_pkg::byteen_t    byteenable,
   output xlat_pkg::data_t      readdata,
   output logic                 readdatavalid,
   output logic                 waitrequest,

   // ----------------------------------------------------------
   // downstream side
   // ----------------------------------------------------------
   output logic                 uav_write,
   output logic                 uav_read,
   output xlat_pkg::uav_addr_t  uav_address,
   output xlat_pkg::uav_burst_t uav_burstcount,
   output xlat_pkg::data_t      uav_writedata,
   output xlat_pkg::byteen_t    uav_byteenable,
   input  xlat_pkg::data_t      uav_readdata,
   input  logic                 uav_readdatavalid,
   input  logic                 uav_waitrequest
);

   // framer to tracker
   logic begin_beat;
   logic begin_burst;

   // tracker to framer
   logic last_beat;

   // ----------------------------------------------------------
   // straight-through paths
   // ----------------------------------------------------------
   assign uav_write      = write;
   assign uav_read       = read;
   assign uav_writedata  = writedata;
   assign uav_byteenable = byteenable;

   assign readdata      = uav_readdata;
   assign readdatavalid = uav_readdatavalid;

   // no acceptance logic of our own, the slave's stall goes back as is
   assign waitrequest = uav_waitrequest;

   // ----------------------------------------------------------
   // transfer and burst framing
   // ----------------------------------------------------------
   transfer_framer u_framer (
      .clk             (clk),
      .reset           (reset),
      .write           (write),
      .read            (read),
      .uav_waitrequest (uav_waitrequest),
      .last_beat       (last_beat),
      .begin_beat      (begin_beat),
      .begin_burst     (begin_burst)
   );

   // ----------------------------------------------------------
   // address and length conversion
   // ----------------------------------------------------------
   burst_tracker u_tracker (
      .clk             (clk),
      .reset           (reset),
      .write           (write),
      .address         (address),
      .burstcount      (burstcount),
      .begin_beat      (begin_beat),
      .begin_burst     (begin_burst),
      .uav_waitrequest (uav_waitrequest),
      .uav_address     (uav_address),
      .uav_burstcount  (uav_burstcount),
      .last_beat       (last_beat)
   );

endmodule

`default_nettype wire

//--- verif/master_translator_assert.sv
`default_nettype none

// protocol checks on the downstream side of the translator
module master_translator_assert (
   input logic                 clk,
   input logic                 reset,
   input logic                 uav_waitrequest,
   input logic                 uav_write,
   input logic                 uav_read,
   input xlat_pkg::uav_addr_t  uav_address,
   input xlat_pkg::uav_burst_t uav_burstcount
);
   import xlat_pkg::*;

   logic cmd_valid;
   int   fail_count = 0;

   assign cmd_valid = uav_write | uav_read;

   // ----------------------------------------------------------
   // a stalled command keeps its address and count
   // ----------------------------------------------------------
   address_held: assert property (@(posedge clk) disable iff (reset)
      cmd_valid && uav_waitrequest |=> $stable(uav_address))
      else begin
         fail_count++;
         $error("uav_address changed while the slave stalled");
      end

   count_held: assert property (@(posedge clk) disable iff (reset)
      cmd_valid && uav_waitrequest |=> $stable(uav_burstcount))
      else begin
         fail_count++;
         $error("uav_burstcount changed while the slave stalled");
      end

   // byte counts are whole words and never zero
   count_legal: assert property (@(posedge clk) disable iff (reset)
      cmd_valid |-> (uav_burstcount != '0) && ((uav_burstcount % SYMBOLS_PER_WORD) == 0))
      else begin
         fail_count++;
         $error("uav_burstcount is zero or not a whole number of words");
      end

endmodule

bind master_translator master_translator_assert u_assert (
   .clk             (clk),
   .reset           (reset),
   .uav_waitrequest (uav_waitrequest),
   .uav_write       (uav_write),
   .uav_read        (uav_read),
   .uav_address     (uav_address),
   .uav_burstcount  (uav_burstcount)
);

`default_nettype wire

//--- verif/master_translator_tb.sv
`default_nettype none

module master_translator_tb;
   import xlat_pkg::*;

   localparam int NUM_ROWS     = 9;
   localparam int RESET_CYCLES = 16;
   localparam int MAX_STALL    = 4;
   localparam int READ_LAT     = 2;
   localparam logic [63:0] RD_XOR = 64'h0000_0003_5A5A_C3C3;

   logic       clk;
   logic       reset;
   logic       write;
   logic       read;
   av_addr_t   address;
   burstlen_t  burstcount;
   data_t      writedata;
   byteen_t    byteenable;
   data_t      readdata;
   logic       readdatavalid;
   logic       waitrequest;
   logic       uav_write;
   logic       uav_read;
   uav_addr_t  uav_address;
   uav_burst_t uav_burstcount;
   data_t      uav_writedata;
   byteen_t    uav_byteenable;
   data_t      uav_readdata;
   logic       uav_readdatavalid;
   logic       uav_waitrequest;

   // one row per transaction with kind, word address, word count and data base
   logic      row_is_read [NUM_ROWS];
   av_addr_t  row_addr    [NUM_ROWS];
   burstlen_t row_len     [NUM_ROWS];
   data_t     row_data    [NUM_ROWS];

   int          errors = 0;
   int          checks = 0;
   int          cycle = 0;
   int          cycle_limit = 0;
   integer      seed = 60;
   // write beats the slave has taken since it last saw a burst end
   int          wr_beats = 0;
   // length of the last write burst the slave saw end
   int          wr_burst_len = 0;
   int          stall_run = 0;
   int          last_due = 0;
   data_t       exp_rd_q [$];
   logic [63:0] rd_addr_q [$];
   int          rd_due_q [$];

   master_translator UUT (
      .clk (clk), .reset (reset),
      .write (write), .read (read), .address (address), .burstcount (burstcount),
      .writedata (writedata), .byteenable (byteenable), .readdata (readdata),
      .readdatavalid (readdatavalid), .waitrequest (waitrequest),
      .uav_write (uav_write), .uav_read (uav_read), .uav_address (uav_address),
      .uav_burstcount (uav_burstcount), .uav_writedata (uav_writedata),
      .uav_byteenable (uav_byteenable), .uav_readdata (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid), .uav_waitrequest (uav_waitrequest)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %s: expected 0x%0h, actual 0x%0h at %0t", name, expected, actual,
                  $time);
      end
   endtask

   // byte address of word k in a burst starting at a word address
   function automatic logic [63:0] beat_byte_address(input av_addr_t word_addr, input int k);
      return (64'(word_addr) * 4) + 64'(k * 4);
   endfunction

   task automatic set_row(input int r, input logic is_read, input av_addr_t addr,
                          input burstlen_t len, input data_t data);
      row_is_read[r] = is_read;
      row_addr[r]    = addr;
      row_len[r]     = len;
      row_data[r]    = data;
   endtask

   task automatic load_table();
      set_row(0, 1'b0, 32'h0000_0010, 4'd1, 32'hA5A5_0000);
      set_row(1, 1'b0, 32'h0000_0100, 4'd8, 32'h1000_0000);
      set_row(2, 1'b1, 32'h0000_0100, 4'd8, 32'h0);
      set_row(3, 1'b0, 32'h0000_2000, 4'd15, 32'h2000_0000);
      set_row(4, 1'b1, 32'h3FFF_FFF0, 4'd4, 32'h0);
      set_row(5, 1'b1, 32'h0000_0040, 4'd1, 32'h0);
      set_row(6, 1'b0, 32'hFFFF_FFFC, 4'd3, 32'h3000_0000);
      set_row(7, 1'b1, 32'h0000_0044, 4'd2, 32'h0);
      set_row(8, 1'b0, 32'h0000_0800, 4'd2, 32'h4000_0000);
   endtask

   // worst case has every beat fully stalled and every read waiting for its data
   function automatic int cycle_budget();
      int total;
      int r;
      total = RESET_CYCLES;
      for (r = 0; r < NUM_ROWS; r++) begin
         if (row_is_read[r]) begin
            total += (MAX_STALL + 1) + READ_LAT + int'(row_len[r]);
         end else begin
            total += int'(row_len[r]) * (MAX_STALL + 1);
         end
      end
      return 2 * total + 100;
   endfunction

   // ------------------------------------------------------------
   // master model
   // ------------------------------------------------------------

   // holds the driven beat until accepted and checks the bus every cycle
   task automatic hold_beat(input string name, input logic [63:0] exp_addr,
                            input int exp_count);
      logic accepted;
      accepted = 1'b0;
      while (!accepted) begin
         #1;
         check_value({name, " waitrequest"}, uav_waitrequest, waitrequest);
         check_value({name, " uav_write"}, write, uav_write);
         check_value({name, " uav_read"}, read, uav_read);
         check_value({name, " uav_address"}, exp_addr, uav_address);
         check_value({name, " uav_burstcount"}, exp_count, uav_burstcount);
         if (write) begin
            check_value({name, " uav_writedata"}, writedata, uav_writedata);
            check_value({name, " uav_byteenable"}, byteenable, uav_byteenable);
         end
         accepted = !waitrequest;
         @(negedge clk);
      end
   endtask

   task automatic run_write(input int r);
      int    k;
      string name;
      name         = $sformatf("row %0d write", r);
      wr_burst_len = 0;
      for (k = 0; k < int'(row_len[r]); k++) begin
         write      = 1'b1;
         read       = 1'b0;
         address    = row_addr[r];
         burstcount = row_len[r];
         writedata  = row_data[r] + data_t'(k);
         byteenable = byteen_t'(4'hF >> (k % 4));
         hold_beat(name, beat_byte_address(row_addr[r], k), 4 * (int'(row_len[r]) - k));
      end
      check_value({name, " beat count"}, row_len[r], wr_burst_len);
   endtask

   task automatic run_read(input int r);
      int    k;
      string name;
      name = $sformatf("row %0d read", r);
      for (k = 0; k < int'(row_len[r]); k++) begin
         exp_rd_q.push_back(data_t'(beat_byte_address(row_addr[r], k) ^ RD_XOR));
      end
      write      = 1'b0;
      read       = 1'b1;
      address    = row_addr[r];
      burstcount = row_len[r];
      writedata  = '0;
      byteenable = '1;
      hold_beat(name, beat_byte_address(row_addr[r], 0), 4 * int'(row_len[r]));
   endtask

   // read data as seen by the master
   always @(negedge clk) begin
      #1;
      if (!reset) begin
         check_value("readdatavalid", uav_readdatavalid, readdatavalid);
         if (readdatavalid && exp_rd_q.size() == 0) begin
            errors++;
            $display("Error: read data arrived with no read outstanding at %0t", $time);
         end else if (readdatavalid) begin
            check_value("read data", exp_rd_q.pop_front(), readdata);
         end
      end
   end

   // ------------------------------------------------------------
   // downstream slave model
   // ------------------------------------------------------------
   initial begin
      int n;
      int i;
      int due;
      uav_waitrequest   = 1'b0;
      uav_readdatavalid = 1'b0;
      uav_readdata      = '0;
      forever begin
         @(negedge clk);
         if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
            uav_readdatavalid = 1'b1;
            uav_readdata      = data_t'(rd_addr_q.pop_front() ^ RD_XOR);
            due               = rd_due_q.pop_front();
         end else begin
            uav_readdatavalid = 1'b0;
            uav_readdata      = '0;
         end
         // random stalls of at most MAX_STALL cycles in a row
         if (reset || stall_run >= MAX_STALL) begin
            uav_waitrequest = 1'b0;
            stall_run       = 0;
         end else begin
            uav_waitrequest = (($random(seed) & 7) < 3);
            stall_run       = uav_waitrequest ? stall_run + 1 : 0;
         end
         #1;
         if (!reset && !uav_waitrequest && uav_write) begin
            wr_beats++;
            // a beat that carries a single word closes the burst
            if (uav_burstcount == uav_burst_t'(4)) begin
               wr_burst_len = wr_beats;
               wr_beats     = 0;
            end
         end
         if (!reset && !uav_waitrequest && uav_read) begin
            n = int'(uav_burstcount) / 4;
            for (i = 0; i < n; i++) begin
               due      = (cycle + READ_LAT > last_due) ? cycle + READ_LAT : last_due + 1;
               last_due = due;
               rd_addr_q.push_back(64'(uav_address) + 64'(4 * i));
               rd_due_q.push_back(due);
            end
         end
      end
   end

   // ------------------------------------------------------------
   // run control
   // ------------------------------------------------------------
   initial begin
      wait (cycle_limit > 0 && cycle >= cycle_limit);
      $display("Timeout: run still busy after %0d cycles, %0d errors in %0d checks",
               cycle, errors, checks);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      int r;
      reset      = 1'b1;
      write      = 1'b0;
      read       = 1'b0;
      address    = '0;
      burstcount = '0;
      writedata  = '0;
      byteenable = '0;
      load_table();
      cycle_limit = cycle_budget();
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      // rows follow each other with no idle cycle
      for (r = 0; r < NUM_ROWS; r++) begin
         if (row_is_read[r]) begin
            run_read(r);
         end else begin
            run_write(r);
         end
      end
      write = 1'b0;
      read  = 1'b0;
      while (exp_rd_q.size() > 0) @(negedge clk);
      repeat (4) @(negedge clk);
      $display("Run complete: %0d errors in %0d checks, %0d assertion failures",
               errors, checks, UUT.u_assert.fail_count);
      if (errors == 0 && UUT.u_assert.fail_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- master_translator.f
rtl/xlat_pkg.sv
rtl/transfer_framer.sv
rtl/burst_tracker.sv
rtl/master_translator.sv
verif/master_translator_assert.sv
verif/master_translator_tb.sv
